// File: catalina_io.f
source/catalina_sample_pkg.sv
source/catalina_bus_pkg.sv
source/catalina_mode_ctrl.sv
source/catalina_rx_demux.sv
source/catalina_tx_mux.sv
source/catalina_io.sv
verif/catalina_io_checker.sv
verif/catalina_io_tb.sv

// File: Bender.yml
# Sample interface between baseband and RF transceiver
package:
  name: catalina_io

sources:
  # Packages first, the RTL depends on them
  - source/catalina_sample_pkg.sv
  - source/catalina_bus_pkg.sv
  # Design, leaf modules before the top level
  - source/catalina_mode_ctrl.sv
  - source/catalina_rx_demux.sv
  - source/catalina_tx_mux.sv
  - source/catalina_io.sv
  # Simulation only
  - target: test
    files:
      - verif/catalina_io_checker.sv
      - verif/catalina_io_tb.sv

// File: verif/catalina_io_tb.sv
// Testbench with clock, reset, xorshift stimulus, error counts and closing message
`timescale 1ns/1ps

module catalina_io_tb;

   localparam int SYNC_STAGES = 2;

   //--------------------------------------------------
   // DUT and clock
   //--------------------------------------------------

   logic                          siso_clk;
   logic                          rst_n_i;
   logic                          mimo_i;
   catalina_bus_pkg::rx_pair_t    rx_bus_i;
   catalina_bus_pkg::tx_pair_t    tx_bus_o;
   catalina_sample_pkg::dual_iq_t tx_dual_i;
   catalina_sample_pkg::dual_iq_t rx_dual_o;
   logic                          radio_strobe_o;

   logic [31:0]                   rng_state;
   int                            timeout_cnt;
   int                            assert_cnt;
   // Fixed pairs for the MIMO RX pattern
   catalina_bus_pkg::rx_pair_t    pair_a;
   catalina_bus_pkg::rx_pair_t    pair_b;

   catalina_io #(
      .SYNC_STAGES (SYNC_STAGES)
   ) dut_i (
      .siso_clk       (siso_clk),
      .rst_n_i        (rst_n_i),
      .mimo_i         (mimo_i),
      .rx_bus_i       (rx_bus_i),
      .tx_bus_o       (tx_bus_o),
      .tx_dual_i      (tx_dual_i),
      .rx_dual_o      (rx_dual_o),
      .radio_strobe_o (radio_strobe_o)
   );

   // 8 ns period
   initial begin
      siso_clk = 1'b0;
      forever #4 siso_clk = ~siso_clk;
   end

   //--------------------------------------------------
   // Random values
   //--------------------------------------------------

   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   // Advances the generator state
   function automatic logic [31:0] next_word();
      rng_state = xorshift32(rng_state);
      return rng_state;
   endfunction

   // Roughly one in four is zero when zero_ok is set
   function automatic catalina_sample_pkg::sample_t draw_sample(input bit zero_ok);
      logic [31:0] w;
      w = next_word();
      if (zero_ok && (w[31:30] == 2'b00)) begin
         return '0;
      end else begin
         return w[catalina_sample_pkg::SAMPLE_W-1:0];
      end
   endfunction

   //--------------------------------------------------
   // Stimulus tasks
   //--------------------------------------------------

   // New random RX pair and TX channels, 1 ns after the edge
   task automatic drive_random_cycle();
      logic [31:0] w;
      @(posedge siso_clk);
      #1;
      w = next_word();
      rx_bus_i.i       = draw_sample(1'b0);
      rx_bus_i.q       = draw_sample(1'b0);
      rx_bus_i.frame   = w[0];
      // Zeros on ch0 exercise the loopback fallback to ch1
      tx_dual_i.ch0.i  = draw_sample(1'b1);
      tx_dual_i.ch0.q  = draw_sample(1'b1);
      tx_dual_i.ch1.i  = draw_sample(1'b1);
      tx_dual_i.ch1.q  = draw_sample(1'b1);
   endtask

   task automatic drive_rx_pair(input catalina_bus_pkg::rx_pair_t p);
      @(posedge siso_clk);
      #1;
      rx_bus_i = p;
   endtask

   // Waits for run_len cycles in a row with the strobe at level
   task automatic wait_strobe_run(input logic level, input int run_len, input int limit,
                                  input string what);
      int run;
      int cycles;
      run    = 0;
      cycles = 0;
      while ((run < run_len) && (cycles < limit)) begin
         @(posedge siso_clk);
         #1;
         cycles++;
         if (radio_strobe_o == level) begin
            run++;
         end else begin
            run = 0;
         end
      end
      if (run < run_len) begin
         timeout_cnt++;
         $display("Timeout: radio strobe never settled while waiting for %s", what);
      end
   endtask

   //--------------------------------------------------
   // Test sequence
   //--------------------------------------------------

   initial begin
      rst_n_i     = 1'b0;
      mimo_i      = 1'b0;
      rx_bus_i    = '0;
      tx_dual_i   = '0;
      rng_state   = 32'h4f7e_e956;
      timeout_cnt = 0;
      repeat (16) @(posedge siso_clk);
      #1 rst_n_i = 1'b1;

      // SISO replication and loopback
      wait_strobe_run(1'b1, 4, 40, "SISO after reset");
      repeat (40) drive_random_cycle();

      // MIMO strobe and TX interleave
      @(posedge siso_clk);
      #1 mimo_i = 1'b1;
      wait_strobe_run(1'b0, 1, 40, "first MIMO gap");
      repeat (40) drive_random_cycle();

      // MIMO RX demux with a steady A/B pattern
      pair_a.i     = draw_sample(1'b0);
      pair_a.q     = draw_sample(1'b0);
      pair_a.frame = 1'b1;
      pair_b.i     = draw_sample(1'b0);
      pair_b.q     = draw_sample(1'b0);
      pair_b.frame = 1'b0;
      repeat (6) begin
         drive_rx_pair(pair_a);
         drive_rx_pair(pair_b);
      end

      // Back to SISO
      @(posedge siso_clk);
      #1 mimo_i = 1'b0;
      wait_strobe_run(1'b1, 4, 40, "return to SISO");
      repeat (30) drive_random_cycle();
      repeat (4) @(posedge siso_clk);

      assert_cnt = dut_i.checker_i.fail_cnt;
      $display("Errors: %0d assertion, %0d timeout", assert_cnt, timeout_cnt);
      if ((assert_cnt == 0) && (timeout_cnt == 0)) begin
         $display("test passed");
      end else begin
         $display("test failed");
      end
      $finish;
   end

endmodule

// File: verif/catalina_io_checker.sv
// Port-level concurrent assertions for the sample interface, bound to the top level
`timescale 1ns/1ps

module catalina_io_checker #(
   // Same synchronizer depth as the DUT
   parameter int SYNC_STAGES = 2
) (
   input logic                          siso_clk,
   input logic                          rst_n_i,
   input logic                          mimo_i,
   input catalina_bus_pkg::rx_pair_t    rx_bus_i,
   input catalina_bus_pkg::tx_pair_t    tx_bus_o,
   input catalina_sample_pkg::dual_iq_t tx_dual_i,
   input catalina_sample_pkg::dual_iq_t rx_dual_o,
   input logic                          radio_strobe_o
);

   // Cycles of steady mode level before a mode counts as settled
   localparam int SETTLE = SYNC_STAGES + 4;

   // Failed assertions so far
   int fail_cnt = 0;

   //--------------------------------------------------
   // Input history
   //--------------------------------------------------

   logic                          mimo_prev_q;
   // Saturating count of cycles since mimo_i last changed
   logic [7:0]                    run_q;
   // Strobe of the previous cycle, which marks the first TX pair
   logic                          strobe_prev_q;
   catalina_bus_pkg::rx_pair_t    rx_hist_q [1:5];
   catalina_sample_pkg::dual_iq_t tx_d1_q;
   catalina_sample_pkg::dual_iq_t tx_d2_q;

   always_ff @(posedge siso_clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         mimo_prev_q   <= 1'b0;
         run_q         <= '0;
         strobe_prev_q <= 1'b0;
         tx_d1_q       <= '0;
         tx_d2_q       <= '0;
         for (int n = 1; n <= 5; n++) begin
            rx_hist_q[n] <= '0;
         end
      end else begin
         mimo_prev_q   <= mimo_i;
         strobe_prev_q <= radio_strobe_o;
         if (mimo_i != mimo_prev_q) begin
            run_q <= '0;
         end else if (run_q != 8'hff) begin
            run_q <= run_q + 8'd1;
         end
         tx_d1_q      <= tx_dual_i;
         tx_d2_q      <= tx_d1_q;
         rx_hist_q[1] <= rx_bus_i;
         for (int n = 2; n <= 5; n++) begin
            rx_hist_q[n] <= rx_hist_q[n-1];
         end
      end
   end

   //--------------------------------------------------
   // Expected values
   //--------------------------------------------------

   logic                          siso_settled;
   logic                          mimo_settled;
   logic                          rx_pattern;
   catalina_sample_pkg::dual_iq_t siso_rx_exp;
   catalina_bus_pkg::tx_pair_t    siso_tx_exp;
   catalina_bus_pkg::tx_pair_t    tx_first_exp;
   catalina_bus_pkg::tx_pair_t    tx_second_exp;
   catalina_sample_pkg::dual_iq_t mimo_rx_exp;

   assign siso_settled = !mimo_prev_q && (run_q >= SETTLE);
   assign mimo_settled = mimo_prev_q && (run_q >= SETTLE);

   // Frame-1 pair A and frame-0 pair B alternating for six pairs
   assign rx_pattern = !rx_bus_i.frame && rx_hist_q[1].frame
                       && (rx_hist_q[2] == rx_bus_i) && (rx_hist_q[4] == rx_bus_i)
                       && (rx_hist_q[3] == rx_hist_q[1]) && (rx_hist_q[5] == rx_hist_q[1]);

   always_comb begin
      // SISO RX takes the pair from two cycles back on both channels
      siso_rx_exp.ch0.i = rx_hist_q[2].i;
      siso_rx_exp.ch0.q = rx_hist_q[2].q;
      siso_rx_exp.ch1   = siso_rx_exp.ch0;
      // SISO TX takes ch0 per component unless it is zero
      siso_tx_exp.i = (tx_d1_q.ch0.i != '0) ? tx_d1_q.ch0.i : tx_d1_q.ch1.i;
      siso_tx_exp.q = (tx_d1_q.ch0.q != '0) ? tx_d1_q.ch0.q : tx_d1_q.ch1.q;
      siso_tx_exp.frame_rise = 1'b1;
      siso_tx_exp.frame_fall = 1'b0;
      // MIMO TX sends ch1 first with both frame halves high
      tx_first_exp = {tx_d1_q.ch1.i, tx_d1_q.ch1.q, 2'b11};
      // Then ch0 from one more cycle back with frame low
      tx_second_exp = {tx_d2_q.ch0.i, tx_d2_q.ch0.q, 2'b00};
      // MIMO RX puts the frame-0 pair on ch0 and the frame-1 pair on ch1
      mimo_rx_exp.ch0.i = rx_bus_i.i;
      mimo_rx_exp.ch0.q = rx_bus_i.q;
      mimo_rx_exp.ch1.i = rx_hist_q[1].i;
      mimo_rx_exp.ch1.q = rx_hist_q[1].q;
   end

   //--------------------------------------------------
   // Assertions
   //--------------------------------------------------

   // Sampled on the falling edge halfway between input changes
   reset_tx_a: assert property (@(negedge siso_clk) $rose(rst_n_i) |-> tx_bus_o == '0)
      else begin
         $error("FAIL reset_tx: expected %h actual %h", '0, tx_bus_o);
         fail_cnt++;
      end

   // Strobe follows the new mode level once the synchronizer has passed it
   siso_strobe_a: assert property (@(negedge siso_clk) disable iff (!rst_n_i)
      !mimo_prev_q && (run_q >= SYNC_STAGES) |-> radio_strobe_o)
      else begin
         $error("FAIL siso_strobe: expected 1 actual %b", radio_strobe_o);
         fail_cnt++;
      end

   siso_rx_a: assert property (@(negedge siso_clk) disable iff (!rst_n_i)
      siso_settled |-> rx_dual_o == siso_rx_exp)
      else begin
         $error("FAIL siso_rx: expected %h actual %h", siso_rx_exp, rx_dual_o);
         fail_cnt++;
      end

   siso_tx_a: assert property (@(negedge siso_clk) disable iff (!rst_n_i)
      siso_settled |-> tx_bus_o == siso_tx_exp)
      else begin
         $error("FAIL siso_tx: expected %h actual %h", siso_tx_exp, tx_bus_o);
         fail_cnt++;
      end

   mimo_strobe_a: assert property (@(negedge siso_clk) disable iff (!rst_n_i)
      mimo_prev_q && (run_q >= SYNC_STAGES) |-> radio_strobe_o != strobe_prev_q)
      else begin
         $error("FAIL mimo_strobe: expected %b actual %b", ~strobe_prev_q, radio_strobe_o);
         fail_cnt++;
      end

   mimo_tx_first_a: assert property (@(negedge siso_clk) disable iff (!rst_n_i)
      mimo_settled && strobe_prev_q |-> tx_bus_o == tx_first_exp)
      else begin
         $error("FAIL mimo_tx_first: expected %h actual %h", tx_first_exp, tx_bus_o);
         fail_cnt++;
      end

   mimo_tx_second_a: assert property (@(negedge siso_clk) disable iff (!rst_n_i)
      mimo_settled && strobe_prev_q |=> tx_bus_o == tx_second_exp)
      else begin
         $error("FAIL mimo_tx_second: expected %h actual %h", tx_second_exp, tx_bus_o);
         fail_cnt++;
      end

   mimo_rx_a: assert property (@(negedge siso_clk) disable iff (!rst_n_i)
      mimo_settled && rx_pattern |-> rx_dual_o == mimo_rx_exp)
      else begin
         $error("FAIL mimo_rx: expected %h actual %h", mimo_rx_exp, rx_dual_o);
         fail_cnt++;
      end

endmodule

bind catalina_io catalina_io_checker #(
   .SYNC_STAGES (SYNC_STAGES)
) checker_i (
   .siso_clk       (siso_clk),
   .rst_n_i        (rst_n_i),
   .mimo_i         (mimo_i),
   .rx_bus_i       (rx_bus_i),
   .tx_bus_o       (tx_bus_o),
   .tx_dual_i      (tx_dual_i),
   .rx_dual_o      (rx_dual_o),
   .radio_strobe_o (radio_strobe_o)
);

// File: source/catalina_io.sv
// Top level joining mode control, RX demux and TX mux
`timescale 1ns/1ps

module catalina_io #(
   // Mode synchronizer depth, passed to the control block
   parameter int SYNC_STAGES = 2
) (
   input  logic                          siso_clk,
   input  logic                          rst_n_i,
   // Asynchronous SISO/MIMO select
   input  logic                          mimo_i,

   // Transceiver side
   input  catalina_bus_pkg::rx_pair_t    rx_bus_i,
   output catalina_bus_pkg::tx_pair_t    tx_bus_o,

   // Baseband side
   input  catalina_sample_pkg::dual_iq_t tx_dual_i,
   output catalina_sample_pkg::dual_iq_t rx_dual_o,
   // Marks valid baseband samples, stands in for radio_clk
   output logic                          radio_strobe_o
);

   //--------------------------------------------------
   // Control
   //--------------------------------------------------

   // Shared by both datapaths so RX and TX keep the same phase
   catalina_bus_pkg::mode_t mode;

   catalina_mode_ctrl #(
      .SYNC_STAGES (SYNC_STAGES)
   ) mode_ctrl_i (
      .siso_clk (siso_clk),
      .rst_n_i  (rst_n_i),
      .mimo_i   (mimo_i),
      .mode_o   (mode)
   );

   assign radio_strobe_o = mode.strobe;

   //--------------------------------------------------
   // Datapaths
   //--------------------------------------------------

   catalina_rx_demux rx_demux_i (
      .siso_clk  (siso_clk),
      .rst_n_i   (rst_n_i),
      .mode_i    (mode),
      .rx_bus_i  (rx_bus_i),
      .rx_dual_o (rx_dual_o)
   );

   catalina_tx_mux tx_mux_i (
      .siso_clk  (siso_clk),
      .rst_n_i   (rst_n_i),
      .mode_i    (mode),
      .tx_dual_i (tx_dual_i),
      .tx_bus_o  (tx_bus_o)
   );

endmodule

// File: source/catalina_tx_mux.sv
// Dual-channel to TX bus pair mux with loopback select and frame generation
`timescale 1ns/1ps

module catalina_tx_mux (
   input  logic                          siso_clk,
   input  logic                          rst_n_i,
   // Synchronized mode and sample strobe
   input  catalina_bus_pkg::mode_t       mode_i,
   // Both channels from the baseband
   input  catalina_sample_pkg::dual_iq_t tx_dual_i,
   // One pair per cycle towards the transceiver
   output catalina_bus_pkg::tx_pair_t    tx_bus_o
);

   //--------------------------------------------------
   // SISO loopback select
   //--------------------------------------------------

   // Lets either channel drive the bus in SISO
   // Mainly used by the codec loopback test, where only one DUC is live
   // I and Q choose independently
   catalina_sample_pkg::iq_t loop_iq;

   assign loop_iq.i = (tx_dual_i.ch0.i != '0) ? tx_dual_i.ch0.i : tx_dual_i.ch1.i;
   assign loop_iq.q = (tx_dual_i.ch0.q != '0) ? tx_dual_i.ch0.q : tx_dual_i.ch1.q;

   //--------------------------------------------------
   // Pair serializer
   //--------------------------------------------------

   // Pair currently on the bus
   catalina_sample_pkg::iq_t out_q;
   // ch0 parked for the second half of a MIMO sample
   catalina_sample_pkg::iq_t hold_q;

   always_ff @(posedge siso_clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         out_q  <= '0;
         hold_q <= '0;
      end else if (mode_i.strobe) begin
         // ch1 goes first in MIMO, again due to the swapped labels
         if (mode_i.mimo) begin
            out_q <= tx_dual_i.ch1;
         end else begin
            out_q <= loop_iq;
         end
         hold_q <= tx_dual_i.ch0;
      end else begin
         // Second cycle of a MIMO sample
         out_q <= hold_q;
      end
   end

   //--------------------------------------------------
   // Frame
   //--------------------------------------------------

   // Strobe delayed to line up with the pair it marks
   logic strobe_d_q;

   always_ff @(posedge siso_clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         strobe_d_q <= 1'b0;
      end else begin
         strobe_d_q <= mode_i.strobe;
      end
   end

   //--------------------------------------------------
   // Bus output
   //--------------------------------------------------

   assign tx_bus_o.i          = out_q.i;
   assign tx_bus_o.q          = out_q.q;
   // Rising half high for the first pair of a sample
   assign tx_bus_o.frame_rise = strobe_d_q;
   // Falling half: SISO toggles frame per pair (1/0),
   // MIMO holds it high across the first pair
   assign tx_bus_o.frame_fall = strobe_d_q & mode_i.mimo;

endmodule

// File: source/catalina_rx_demux.sv
// RX bus pair to dual-channel demux with strobe-aligned output stage
`timescale 1ns/1ps

module catalina_rx_demux (
   input  logic                          siso_clk,
   input  logic                          rst_n_i,
   // Synchronized mode and sample strobe
   input  catalina_bus_pkg::mode_t       mode_i,
   // One captured pair per cycle from the transceiver
   input  catalina_bus_pkg::rx_pair_t    rx_bus_i,
   // Both channels towards the baseband
   output catalina_sample_pkg::dual_iq_t rx_dual_o
);

   //--------------------------------------------------
   // Pair unpacking
   //--------------------------------------------------

   // I/Q part of the incoming pair, frame handled apart
   catalina_sample_pkg::iq_t pair_iq;

   assign pair_iq.i = rx_bus_i.i;
   assign pair_iq.q = rx_bus_i.q;

   //--------------------------------------------------
   // Channel stage
   //--------------------------------------------------

   // Frame-1 pair waiting for its frame-0 partner
   catalina_sample_pkg::iq_t      hold_q;
   // Assembled channels, one cycle after the bus
   catalina_sample_pkg::dual_iq_t chan_q;

   always_ff @(posedge siso_clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         hold_q <= '0;
         chan_q <= '0;
      end else if (mode_i.mimo) begin
         if (rx_bus_i.frame) begin
            // First pair of the sample, park it
            hold_q <= pair_iq;
         end else begin
            // Second pair completes the sample
            // Channel labels on the board are swapped against the
            // transceiver docs, so the frame-0 pair lands on ch0
            chan_q.ch0 <= pair_iq;
            chan_q.ch1 <= hold_q;
         end
      end else begin
         // SISO replicates onto both channels
         // Either downstream DDC can then be used
         chan_q.ch0 <= pair_iq;
         chan_q.ch1 <= pair_iq;
      end
   end

   //--------------------------------------------------
   // Output stage
   //--------------------------------------------------

   // Registered channel pair presented to the baseband
   catalina_sample_pkg::dual_iq_t out_q;

   // Strobe is always high in SISO, so this copies every cycle there
   // In MIMO it only moves on the sample phase, keeping ch0/ch1
   // stable for the whole two-cycle sample period
   always_ff @(posedge siso_clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         out_q <= '0;
      end else if (mode_i.strobe) begin
         out_q <= chan_q;
      end
   end

   assign rx_dual_o = out_q;

endmodule

// File: source/catalina_mode_ctrl.sv
// Mode level synchronizer and MIMO sample strobe generator
`timescale 1ns/1ps

module catalina_mode_ctrl #(
   // Depth of the mode synchronizer, two or more
   parameter int SYNC_STAGES = 2
) (
   input  logic                    siso_clk,
   input  logic                    rst_n_i,
   // Asynchronous mode level from the host side
   input  logic                    mimo_i,
   // Synchronized mode and strobe for both datapaths
   output catalina_bus_pkg::mode_t mode_o
);

   //--------------------------------------------------
   // Mode synchronizer
   //--------------------------------------------------

   // Bit 0 takes the raw level, the top bit is the safe copy
   logic [SYNC_STAGES-1:0] sync_q;
   logic                   mimo_sync;

   always_ff @(posedge siso_clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         // Come out of reset in SISO
         sync_q <= '0;
      end else begin
         sync_q <= {sync_q[SYNC_STAGES-2:0], mimo_i};
      end
   end

   assign mimo_sync = sync_q[SYNC_STAGES-1];

   //--------------------------------------------------
   // Phase toggle
   //--------------------------------------------------

   // Half-rate phase of the MIMO sample clock
   // Parked at 0 in SISO so MIMO always starts on a strobe cycle
   logic phase_q;

   always_ff @(posedge siso_clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         phase_q <= 1'b0;
      end else if (mimo_sync) begin
         phase_q <= ~phase_q;
      end else begin
         phase_q <= 1'b0;
      end
   end

   //--------------------------------------------------
   // Strobe
   //--------------------------------------------------

   // SISO: every cycle carries a full sample
   // MIMO: one sample per two bus pairs, strobe on phase 0
   assign mode_o.mimo   = mimo_sync;
   assign mode_o.strobe = ~mimo_sync | ~phase_q;

endmodule

// File: source/catalina_bus_pkg.sv
// Transceiver-bus pair structs and the mode/strobe control struct
package catalina_bus_pkg;

   //--------------------------------------------------
   // Bus pairs
   //--------------------------------------------------

   // One RX pair after DDR capture
   // I from one edge, Q from the other, frame tags the channel
   typedef struct packed {
      catalina_sample_pkg::sample_t i;
      catalina_sample_pkg::sample_t q;
      logic                         frame;
   } rx_pair_t;

   // One TX pair ahead of DDR launch
   // Frame is split into the two halves sent on each clock edge
   typedef struct packed {
      catalina_sample_pkg::sample_t i;
      catalina_sample_pkg::sample_t q;
      logic                         frame_rise;
      logic                         frame_fall;
   } tx_pair_t;

   //--------------------------------------------------
   // Control
   //--------------------------------------------------

   // Synchronized mode level and sample strobe
   // Strobe is constant high in SISO
   typedef struct packed {
      logic mimo;
      logic strobe;
   } mode_t;

endpackage

// File: source/catalina_sample_pkg.sv
// Sample width, sample type and the baseband-side channel structs
package catalina_sample_pkg;

   //--------------------------------------------------
   // Sample word
   //--------------------------------------------------

   // Converter resolution of the transceiver
   localparam int SAMPLE_W = 12;

   // One I or Q sample as seen by the baseband
   typedef logic [SAMPLE_W-1:0] sample_t;

   //--------------------------------------------------
   // Channel structs
   //--------------------------------------------------

   // One complex sample of a single channel
   typedef struct packed {
      sample_t i;
      sample_t q;
   } iq_t;

   // Both channels side by side
   // In SISO the two halves carry the same pair on RX
   typedef struct packed {
      iq_t ch0;
      iq_t ch1;
   } dual_iq_t;

endpackage
